// ==== tb.f ====
+incdir+rtl
rtl/fp_types_pkg.sv
rtl/fma_op_pkg.sv
rtl/pipe_stage.sv
rtl/fp_mul_lanes.sv
rtl/fp_add_round.sv
rtl/fma_unit.sv
testbench/fma_unit_assert.sv
testbench/fma_unit_tb.sv

// ==== Makefile ====
VERILATOR   := verilator
LINT_FLAGS  := --lint-only --timing --assert
SIM_FLAGS   := --binary --timing --assert
TOP         := fma_unit_tb
RTL_TOP     := fma_unit
FILELIST    := tb.f
OBJ_DIR     := obj_dir
LOG         := sim.log
FAIL_TEXT   := *** FAILED ***
PASS_TEXT   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '$(FAIL_TEXT)' $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -qF '$(PASS_TEXT)' $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/fma_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fma_macros.svh"

module fma_unit_tb;
    import fp_types_pkg::*;
    import fma_op_pkg::*;

    localparam int NUM_REQ    = 300;
    localparam int MAX_CYCLES = NUM_REQ * 6 + 200;

    typedef struct packed {
        tag_t                     tag;
        fma_op_t                  op;
        fp32_t [`FMA_LANES-1:0]   value;
    } expect_t;

    logic                    clk = 1'b0;
    logic                    rst_n;
    logic                    valid_in;
    logic                    ready_in;
    tag_t                    tag_in;
    fma_op_t                 op;
    fp32_t [`FMA_LANES-1:0]  dataa;
    fp32_t [`FMA_LANES-1:0]  datab;
    fp32_t [`FMA_LANES-1:0]  datac;
    logic                    ready_out;
    logic                    valid_out;
    tag_t                    tag_out;
    fp32_t [`FMA_LANES-1:0]  result;

    integer  seed = 32'heb81a7e6;
    expect_t expect_q[$];
    expect_t head;
    expect_t entry;
    int      a_val [`FMA_LANES];
    int      b_val [`FMA_LANES];
    int      c_val [`FMA_LANES];
    int      sent = 0;
    int      received = 0;
    int      errors = 0;
    int      cycle_count = 0;
    int      total_errors;
    logic    fire;

    fma_unit fma_unit_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .tag_in    (tag_in),
        .op        (op),
        .dataa     (dataa),
        .datab     (datab),
        .datac     (datac),
        .ready_out (ready_out),
        .valid_out (valid_out),
        .tag_out   (tag_out),
        .result    (result)
    );

    bind fma_unit fma_unit_assert assert_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .valid_in  (valid_in),
        .ready_in  (ready_in),
        .ready_out (ready_out),
        .valid_out (valid_out),
        .tag_out   (tag_out),
        .result    (result)
    );

    always #50 clk = ~clk;

    // exact encoding of a small integer as a single-precision word.
    function automatic fp32_t int_to_fp32(input int v);
        fp32_t r;
        int    mag;
        int    msb;

        r = '0;
        if (v != 0) begin
            mag = (v < 0) ? -v : v;
            msb = 0;
            for (int k = 0; k < 24; k++) begin
                if (mag[k]) begin
                    msb = k;
                end
            end
            r.sign = (v < 0);
            r.exp  = 8'(127 + msb);
            r.mant = 23'(mag << (23 - msb));
        end
        return r;
    endfunction

    function automatic fp32_t expected_lane(input int a, input int b, input int c,
                                            input fma_op_t f);
        fp32_t r;
        int    sum;

        sum    = f.do_sub ? (a * b - c) : (a * b + c);
        r      = int_to_fp32(sum);
        r.sign = r.sign ^ f.do_neg;
        return r;
    endfunction

    function automatic string op_name(input fma_op_t f);
        case ({f.do_sub, f.do_neg})
            2'b00:   return "mul_add";
            2'b10:   return "mul_sub";
            2'b01:   return "neg_mul_add";
            default: return "neg_mul_sub";
        endcase
    endfunction

    function automatic int rand_operand();
        int v;

        v = $random(seed) % 65;
        if (($random(seed) & 15) == 0) begin
            v = 0;
        end
        return v;
    endfunction

    task automatic new_request();
        valid_in = ($random(seed) & 3) != 0;
        tag_in   = tag_t'(sent);
        op       = 2'($random(seed));
        for (int i = 0; i < `FMA_LANES; i++) begin
            a_val[i] = rand_operand();
            b_val[i] = rand_operand();
            c_val[i] = rand_operand();
            // some lanes cancel exactly under subtraction.
            if (($random(seed) & 7) == 0) begin
                c_val[i] = a_val[i] * b_val[i];
            end
            dataa[i] = int_to_fp32(a_val[i]);
            datab[i] = int_to_fp32(b_val[i]);
            datac[i] = int_to_fp32(c_val[i]);
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        valid_in  = 1'b0;
        tag_in    = '0;
        op        = '0;
        dataa     = '0;
        datab     = '0;
        datac     = '0;
        ready_out = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst_n     = 1'b1;
        ready_out = ($random(seed) & 3) != 0;
        new_request();
        while (sent < NUM_REQ) begin
            @(negedge clk);
            fire = valid_in && ready_in;
            if (fire) begin
                entry.tag = tag_in;
                entry.op  = op;
                for (int i = 0; i < `FMA_LANES; i++) begin
                    entry.value[i] = expected_lane(a_val[i], b_val[i], c_val[i], op);
                end
                expect_q.push_back(entry);
                sent++;
            end
            @(posedge clk);
            #1;
            ready_out = ($random(seed) & 3) != 0;
            if (sent == NUM_REQ) begin
                valid_in = 1'b0;
            end else if (fire || !valid_in) begin
                new_request();
            end
        end
        while (received < NUM_REQ) begin
            @(posedge clk);
            #1;
            ready_out = ($random(seed) & 3) != 0;
        end
        ready_out = 1'b1;
        repeat (4) @(posedge clk);
        total_errors = errors + fma_unit_inst.assert_inst.fail_count;
        $display("%0d sent, %0d received, %0d value errors, %0d assertion errors, %0d queued",
                 sent, received, errors, fma_unit_inst.assert_inst.fail_count, expect_q.size());
        if ((total_errors == 0) && (expect_q.size() == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // outputs are compared mid-cycle, ahead of the edge that completes the transfer.
    always @(negedge clk) begin
        if (rst_n && valid_out && ready_out) begin
            if (expect_q.size() == 0) begin
                $display("a result with tag %0d came out with no request outstanding", tag_out);
                errors++;
            end else begin
                head = expect_q.pop_front();
                assert (tag_out == head.tag) else begin
                    $display("error %s tag expected %0d actual %0d",
                             op_name(head.op), head.tag, tag_out);
                    errors++;
                end
                for (int i = 0; i < `FMA_LANES; i++) begin
                    assert (result[i] == head.value[i]) else begin
                        $display("error %s lane %0d tag %0d expected %h actual %h",
                                 op_name(head.op), i, head.tag, head.value[i], result[i]);
                        errors++;
                    end
                end
                received++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count == MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d results received",
                     cycle_count, received, NUM_REQ);
            $display("*** FAILED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/fma_unit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fma_macros.svh"

module fma_unit_assert (
    input logic                                  clk,
    input logic                                  rst_n,
    input logic                                  valid_in,
    input logic                                  ready_in,
    input logic                                  ready_out,
    input logic                                  valid_out,
    input fma_op_pkg::tag_t                      tag_out,
    input fp_types_pkg::fp32_t [`FMA_LANES-1:0]  result
);
    int fail_count = 0;

    // a reset cycle leaves the unit idle and accepting.
    reset_idle: assert property (@(posedge clk) !rst_n |=> (!valid_out && ready_in))
        else begin
            $error("valid_out high or ready_in low after a reset cycle");
            fail_count++;
        end

    // a refused result freezes the output and closes the request side.
    stall_closed: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && !ready_out) |-> !ready_in)
        else begin
            $error("ready_in high while the output is stalled");
            fail_count++;
        end

    stall_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (valid_out && !ready_out) |=> (valid_out && $stable(result) && $stable(tag_out)))
        else begin
            $error("result or tag_out changed during a stall");
            fail_count++;
        end

    // without a stall in between, an accepted request shows up three samples later.
    latency: assert property (@(posedge clk) disable iff (!rst_n)
        ($past(valid_in && ready_in, 3) && $past(ready_in, 2) && $past(ready_in, 1))
        |-> valid_out)
        else begin
            $error("valid_out missing three cycles after an unstalled request");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== rtl/fma_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fma_macros.svh"

module fma_unit (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     valid_in,
    output logic                                     ready_in,
    input  fma_op_pkg::tag_t                         tag_in,
    input  fma_op_pkg::fma_op_t                      op,
    input  fp_types_pkg::fp32_t [`FMA_LANES-1:0]    dataa,
    input  fp_types_pkg::fp32_t [`FMA_LANES-1:0]    datab,
    input  fp_types_pkg::fp32_t [`FMA_LANES-1:0]    datac,
    input  logic                                     ready_out,
    output logic                                     valid_out,
    output fma_op_pkg::tag_t                         tag_out,
    output fp_types_pkg::fp32_t [`FMA_LANES-1:0]    result
);
    import fp_types_pkg::*;
    import fma_op_pkg::*;

    logic       enable;
    lane_prod_t mul_q;
    lane_prod_t add_in;
    fma_meta_t  meta_in;
    fma_meta_t  meta_tap;
    fma_meta_t  meta_out;

    // the whole pipeline stalls only when a finished result is refused.
    assign enable   = !(valid_out && !ready_out);
    assign ready_in = enable;

    assign meta_in   = '{tag: tag_in, op: op, valid: valid_in};
    assign valid_out = meta_out.valid;
    assign tag_out   = meta_out.tag;

    fp_mul_lanes #(.LANES(`FMA_LANES)) mul_inst (
        .clk    (clk),
        .enable (enable),
        .dataa  (dataa),
        .datab  (datab),
        .datac  (datac),
        .prod   (mul_q)
    );

    pipe_stage #(.DEPTH(1), .payload_t(lane_prod_t)) operand_pipe (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .in     (mul_q),
        .out    (add_in),
        .tap    ()
    );

    pipe_stage #(.DEPTH(`FMA_LATENCY), .payload_t(fma_meta_t)) meta_pipe (
        .clk    (clk),
        .rst_n  (rst_n),
        .enable (enable),
        .in     (meta_in),
        .out    (meta_out),
        .tap    (meta_tap)
    );

    fp_add_round #(.LANES(`FMA_LANES)) add_inst (
        .clk    (clk),
        .enable (enable),
        .prod   (add_in),
        .op     (meta_tap.op),
        .result (result)
    );

endmodule

`default_nettype wire

// ==== rtl/fp_add_round.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fma_macros.svh"

module fp_add_round #(
    parameter int LANES = `FMA_LANES
) (
    input  logic                               clk,
    input  logic                               enable,
    input  fp_types_pkg::fp_prod_t [LANES-1:0] prod,
    input  fma_op_pkg::fma_op_t                op,
    output fp_types_pkg::fp32_t [LANES-1:0]    result
);
    import fp_types_pkg::*;
    import fma_op_pkg::*;

    fp32_t [LANES-1:0] result_d;

    function automatic logic [5:0] lzc51(input logic [50:0] v);
        logic [5:0] n;
        logic       found;

        n     = 6'd51;
        found = 1'b0;
        for (int k = 50; k >= 0; k--) begin
            if (!found && v[k]) begin
                n     = 6'(50 - k);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    function automatic fp32_t add_lane(input fp_prod_t p, input fma_op_t f);
        fp32_t             r;
        logic              c_sign;
        logic              c_zero;
        logic signed [9:0] c_exp;
        logic [47:0]       c_sig;
        logic signed [9:0] p_exp;
        logic [47:0]       p_sig;
        logic              prod_big;
        logic              big_sign;
        logic              small_sign;
        logic signed [9:0] big_exp;
        logic signed [9:0] small_exp;
        logic signed [9:0] diff;
        logic [50:0]       big_ext;
        logic [50:0]       small_ext;
        logic [50:0]       small_al;
        logic [5:0]        sh;
        logic              sticky;
        logic [50:0]       mag;
        logic [5:0]        lz;
        logic [50:0]       norm;
        logic              rnd_up;
        logic [23:0]       mant_r;
        logic signed [9:0] exp_r;

        c_sign = p.addend.sign ^ f.do_sub;
        c_zero = (p.addend.exp == 8'd0);
        c_exp  = $signed({2'b00, p.addend.exp});
        c_sig  = c_zero ? 48'd0 : {1'b1, p.addend.mant, 24'd0};

        // bring the product into [1, 2) so both significands share bit 47.
        p_exp = p.exp + $signed({9'd0, p.sig[47]});
        if (p.zero) begin
            p_sig = 48'd0;
        end else begin
            p_sig = p.sig[47] ? p.sig : {p.sig[46:0], 1'b0};
        end

        prod_big = !p.zero && (c_zero || (p_exp > c_exp) ||
                   ((p_exp == c_exp) && (p_sig >= c_sig)));
        if (prod_big) begin
            big_sign   = p.sign;
            big_exp    = p_exp;
            big_ext    = {1'b0, p_sig, 2'b00};
            small_sign = c_sign;
            small_exp  = c_exp;
            small_ext  = {1'b0, c_sig, 2'b00};
        end else begin
            big_sign   = c_sign;
            big_exp    = c_exp;
            big_ext    = {1'b0, c_sig, 2'b00};
            small_sign = p.sign;
            small_exp  = p_exp;
            small_ext  = {1'b0, p_sig, 2'b00};
        end

        // a negative difference only occurs when the smaller side is zero.
        diff = big_exp - small_exp;
        if (diff < 10'sd0) begin
            sh = 6'd0;
        end else if (diff > 10'sd63) begin
            sh = 6'd63;
        end else begin
            sh = diff[5:0];
        end
        small_al    = small_ext >> sh;
        sticky      = ((small_al << sh) != small_ext);
        small_al[0] = small_al[0] | sticky;

        mag  = (big_sign ^ small_sign) ? big_ext - small_al : big_ext + small_al;
        lz   = lzc51(mag);
        norm = mag << lz;

        // round to nearest, ties to even.
        rnd_up = norm[26] & (norm[27] | (|norm[25:0]));
        mant_r = {1'b0, norm[49:27]} + {23'd0, rnd_up};
        exp_r  = big_exp + 10'sd1 - $signed({4'b0000, lz}) + $signed({9'd0, mant_r[23]});

        r.sign = big_sign;
        r.exp  = exp_r[7:0];
        r.mant = mant_r[22:0];
        if ((mag == 51'd0) || (exp_r <= 10'sd0)) begin
            r = '0;
        end
        r.sign = r.sign ^ f.do_neg;
        return r;
    endfunction

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            result_d[i] = add_lane(prod[i], op);
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            result <= result_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fp_mul_lanes.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fma_macros.svh"

module fp_mul_lanes #(
    parameter int LANES = `FMA_LANES
) (
    input  logic                               clk,
    input  logic                               enable,
    input  fp_types_pkg::fp32_t [LANES-1:0]    dataa,
    input  fp_types_pkg::fp32_t [LANES-1:0]    datab,
    input  fp_types_pkg::fp32_t [LANES-1:0]    datac,
    output fp_types_pkg::fp_prod_t [LANES-1:0] prod
);
    import fp_types_pkg::*;

    fp_prod_t [LANES-1:0] prod_d;

    // the full 48-bit product is kept so that the only rounding
    // happens after the addition.
    function automatic fp_prod_t mul_lane(
        input fp32_t a,
        input fp32_t b,
        input fp32_t c
    );
        fp_prod_t    p;
        logic [23:0] sig_a;
        logic [23:0] sig_b;
        logic        a_zero;
        logic        b_zero;

        a_zero = (a.exp == 8'd0);
        b_zero = (b.exp == 8'd0);
        sig_a  = {1'b1, a.mant};
        sig_b  = {1'b1, b.mant};

        p.sign   = a.sign ^ b.sign;
        p.exp    = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - 10'sd127;
        p.sig    = sig_a * sig_b;
        // denormal operands count as zero.
        p.zero   = a_zero || b_zero;
        p.addend = c;
        return p;
    endfunction

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            prod_d[i] = mul_lane(dataa[i], datab[i], datac[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            prod <= prod_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/pipe_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter int  DEPTH     = 1,
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     enable,
    input  payload_t in,
    output payload_t out,
    output payload_t tap
);
    // tap is the register one ahead of out, so a consumer with its own
    // output register lines up with out.
    localparam int TAP_IDX = (DEPTH > 1) ? DEPTH - 2 : 0;

    payload_t stage_q [DEPTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else if (enable) begin
            stage_q[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign out = stage_q[DEPTH-1];
    assign tap = stage_q[TAP_IDX];

endmodule

`default_nettype wire

// ==== rtl/fma_op_pkg.sv ====
`default_nettype none

`include "fma_macros.svh"

package fma_op_pkg;

    typedef logic [`FMA_TAG_WIDTH-1:0] tag_t;

    // do_sub turns a*b+c into a*b-c, do_neg flips the final sign.
    typedef struct packed {
        logic do_sub;
        logic do_neg;
    } fma_op_t;

    typedef struct packed {
        tag_t    tag;
        fma_op_t op;
        logic    valid;
    } fma_meta_t;

endpackage

`default_nettype wire

// ==== rtl/fp_types_pkg.sv ====
`default_nettype none

`include "fma_macros.svh"

package fp_types_pkg;

    typedef struct packed {
        logic        sign;
        logic [7:0]  exp;
        logic [22:0] mant;
    } fp32_t;

    // exact product of two normal operands.
    // sig has its binary point below bit 46, so its value lies in [1, 4).
    // exp is biased and not yet adjusted for a carry into bit 47.
    typedef struct packed {
        logic              sign;
        logic signed [9:0] exp;
        logic [47:0]       sig;
        logic              zero;
        fp32_t             addend;
    } fp_prod_t;

    typedef fp_prod_t [`FMA_LANES-1:0] lane_prod_t;

endpackage

`default_nettype wire

// ==== rtl/fma_macros.svh ====
`ifndef FMA_MACROS_SVH
`define FMA_MACROS_SVH

// number of independent lanes processed per request.
`define FMA_LANES 2

// width of the request tag carried alongside the data.
`define FMA_TAG_WIDTH 4

// cycles from acceptance to output.
// It follows from the multiply, operand and round registers.
`define FMA_LATENCY 3

`endif
